//--- filelist.f
+incdir+logic
logic/io_links_pkg.sv
logic/io_links_if.sv
logic/io_reg_bank.sv
logic/link_tx_stage.sv
logic/link_rx_stage.sv
logic/link_counters.sv
logic/io_links_top.sv
tb/io_links_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module io_links_tb \
	-o io_links_sim > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/io_links_sim > sim.log 2>&1 || echo "simulator returned an error" >> sim.log
cat sim.log

# A failed check, a timeout or an abort all count as failure
grep -q "Simulation finished: FAIL" sim.log && exit 1
grep -q "simulator returned an error" sim.log && exit 1
exit 0

//--- tb/io_links_tests.txt
# Columns: op name then operands in hex; W addr wdata, R addr expected, I idle_cycles
# D name link in_tdata in_tvalid rx_p rx_n rx_valid exp_tx_data exp_tx_drive exp_out_tdata exp_out_tvalid
D rst_outputs 0 00 0 00 00 0 00 0 00 0
R rst_glb_ctrl 00 00000001
R rst_l0_ctrl 04 00000001
R rst_l1_ctrl 08 00000001
R rst_l0_bits 05 00000000
R rst_l1_seen 0b 00000000
R unmapped_rd 02 00000000
D tx_plain 0 a5 1 00 00 0 a5 1 00 0
W tx_invert_on 04 00000021
D tx_invert 0 a5 1 00 00 0 5a 1 ff 0
W tx_tristate_on 04 00000031
D tx_tristate 0 3c 1 00 00 0 c3 0 ff 0
W tx_run_off 04 00000000
D tx_norun 0 3c 1 00 00 0 3c 0 00 0
W rx_invert_on 04 00000021
D rx_invert 0 00 0 69 96 1 ff 0 96 1
W rx_invert_off 04 00000001
D rx_plain 0 00 0 69 69 1 00 0 69 1
W bypass_on 04 00000009
D byp_first 0 11 1 00 00 0 11 1 00 0
D byp_second 0 22 1 00 00 0 22 1 11 1
D byp_third 0 33 0 00 00 0 33 0 22 1
W cnt_reset_l0 04 00000003
D cnt_w1 0 00 0 ff 00 1 00 0 ff 1
D cnt_w2 0 00 0 0f 0e 1 00 0 0f 1
D cnt_w3 0 00 0 a5 5a 1 00 0 a5 1
R bits_before_latch 05 00000000
W latch_l0 04 00000005
R latch_bit_held 04 00000005
R cnt_bits_l0 05 00000018
R cnt_errs_l0 06 00000011
R cnt_seen_l0 07 00000001
W cnt_reset_l1 08 00000003
D l1_w1 1 00 0 c3 c0 1 00 0 c3 1
D l0_w4 0 00 0 01 00 1 00 0 01 1
W glb_latch 00 00000005
I latch_gap 1
R glb_latch_cleared 00 00000001
R glb_l0_bits 05 00000020
R glb_l0_errs 06 00000012
R glb_l1_bits 09 00000008
R glb_l1_errs 0a 00000002
W cnt_reset_l1b 08 00000003
I reset_gap 1
R only_l1_bits 09 00000000
R keep_l0_bits 05 00000020
W glb_stop 00 00000000
D stop_l0 0 5a 1 ff 00 1 5a 0 ff 0
D stop_l1 1 5a 1 ff 00 1 5a 0 ff 0
R stop_cleared 05 00000000
W glb_run 00 00000001
W ro_write 05 deadbeef
W glb_latch_again 00 00000005
I settle 1
R after_stop_bits 05 00000000

//--- tb/io_links_tb.sv
`timescale 1ns/1ns
`include "io_links_consts.svh"

module io_links_tb;

	localparam int NL = `IO_NLINKS;
	localparam int WW = `IO_WORD_W;
	localparam int NAME_W = 8 * 24;

	logic in_clk160;
	logic arst_n;
	logic [NL-1:0][WW-1:0] in_tdata;
	logic [NL-1:0] in_tvalid;
	logic [NL-1:0][WW-1:0] tx_data;
	logic [NL-1:0] tx_drive;
	logic [NL-1:0][WW-1:0] rx_p_data;
	logic [NL-1:0][WW-1:0] rx_n_data;
	logic [NL-1:0] rx_valid;
	logic [NL-1:0][WW-1:0] out_tdata;
	logic [NL-1:0] out_tvalid;
	logic [`IO_ADDR_W-1:0] reg_addr;
	logic [`IO_REG_W-1:0] reg_wdata;
	logic reg_wr;
	logic reg_rd;
	logic [`IO_REG_W-1:0] reg_rdata;
	logic reg_rdack;
	logic reg_wrack;

	// Run bookkeeping
	int cycles;
	int cycle_limit;
	int n_tests;
	int n_failed;
	int n_errors;
	bit test_bad;
	bit file_ok;

	io_links_top io_links_top_inst (.*);

	//////////////////////////////////////////////////
	// Clock and timeout
	//////////////////////////////////////////////////

	// 4 ns period
	always #2 in_clk160 = ~in_clk160;

	// Budget comes from the test file length
	always @(posedge in_clk160) begin
		cycles = cycles + 1;
		if (cycles > cycle_limit) begin
			$display("timeout: tests did not finish within %0d cycles", cycle_limit);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Drive and check helpers
	//////////////////////////////////////////////////

	// Bus idle, both links silent
	task automatic drive_quiet();
		in_tdata = '0;
		in_tvalid = '0;
		rx_p_data = '0;
		rx_n_data = '0;
		rx_valid = '0;
		reg_addr = '0;
		reg_wdata = '0;
		reg_wr = 1'b0;
		reg_rd = 1'b0;
	endtask

	task automatic compare_field(input logic [NAME_W-1:0] name, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		if (actual !== expected) begin
			$display("error %0s: %s expected %h, actual %h", name, what, expected, actual);
			n_errors++;
			test_bad = 1'b1;
		end
	endtask

	task automatic report_missing(input logic [NAME_W-1:0] name, input string what);
		$display("test %0s: %s did not come one cycle after the strobe", name, what);
		n_errors++;
		test_bad = 1'b1;
	endtask

	// One line per finished test
	task automatic close_test(input logic [NAME_W-1:0] name);
		n_tests++;
		if (test_bad) begin
			n_failed++;
			$display("test %0s failed", name);
		end else begin
			$display("test %0s ok", name);
		end
		test_bad = 1'b0;
	endtask

	// Strobe for one edge, ack checked half a cycle later
	task automatic bus_write(input logic [NAME_W-1:0] name,
		input logic [`IO_ADDR_W-1:0] addr, input logic [31:0] data);
		drive_quiet();
		reg_addr = addr;
		reg_wdata = data;
		reg_wr = 1'b1;
		@(negedge in_clk160);
		reg_wr = 1'b0;
		if (reg_wrack !== 1'b1) begin
			report_missing(name, "write acknowledge");
		end
		close_test(name);
	endtask

	task automatic bus_read(input logic [NAME_W-1:0] name,
		input logic [`IO_ADDR_W-1:0] addr, input logic [31:0] expected);
		drive_quiet();
		reg_addr = addr;
		reg_rd = 1'b1;
		@(negedge in_clk160);
		reg_rd = 1'b0;
		if (reg_rdack !== 1'b1) begin
			report_missing(name, "read acknowledge");
		end else begin
			compare_field(name, "reg_rdata", expected, reg_rdata);
		end
		close_test(name);
	endtask

	// One word on one link, other link held silent
	task automatic stream_word(
		input logic [NAME_W-1:0] name,
		input int link,
		input logic [31:0] word,
		input logic [31:0] valid,
		input logic [31:0] p_word,
		input logic [31:0] n_word,
		input logic [31:0] p_valid,
		input logic [31:0] exp_tx,
		input logic [31:0] exp_drive,
		input logic [31:0] exp_out,
		input logic [31:0] exp_valid
	);
		drive_quiet();
		in_tdata[link] = word[WW-1:0];
		in_tvalid[link] = valid[0];
		rx_p_data[link] = p_word[WW-1:0];
		rx_n_data[link] = n_word[WW-1:0];
		rx_valid[link] = p_valid[0];
		@(negedge in_clk160);
		compare_field(name, "tx_data", exp_tx, 32'(tx_data[link]));
		compare_field(name, "tx_drive", exp_drive, 32'(tx_drive[link]));
		compare_field(name, "out_tdata", exp_out, 32'(out_tdata[link]));
		compare_field(name, "out_tvalid", exp_valid, 32'(out_tvalid[link]));
		close_test(name);
	endtask

	// Random filler, nothing valid so nothing counts
	task automatic idle_words(input int count);
		for (int c = 0; c < count; c++) begin
			drive_quiet();
			for (int l = 0; l < NL; l++) begin
				in_tdata[l] = WW'($urandom);
				rx_p_data[l] = WW'($urandom);
				rx_n_data[l] = WW'($urandom);
			end
			@(negedge in_clk160);
		end
	endtask

	//////////////////////////////////////////////////
	// Test file sequencer
	//////////////////////////////////////////////////

	initial begin : run_tests
		int fd;
		int code;
		int n_lines;
		int link;
		int count;
		int unsigned first_rand;
		logic [7:0] op;
		logic [NAME_W-1:0] name;
		logic [8*160-1:0] line;
		logic [31:0] f [9];

		first_rand = $urandom(32'h94426a30);
		in_clk160 = 1'b0;
		arst_n = 1'b0;
		drive_quiet();
		cycles = 0;
		n_tests = 0;
		n_failed = 0;
		n_errors = 0;
		test_bad = 1'b0;
		n_lines = 0;

		// First pass only counts lines
		fd = $fopen("tb/io_links_tests.txt", "r");
		file_ok = (fd != 0);
		if (file_ok) begin
			while (!$feof(fd)) begin
				code = $fgets(line, fd);
				if (code > 0) begin
					n_lines++;
				end
			end
			$fclose(fd);
			fd = $fopen("tb/io_links_tests.txt", "r");
		end else begin
			$display("cannot open tb/io_links_tests.txt");
		end
		cycle_limit = 3 * n_lines + 50;

		// Reset low for 4 cycles, released on a falling edge
		repeat (4) @(posedge in_clk160);
		@(negedge in_clk160);
		arst_n = 1'b1;

		if (file_ok) begin
			code = $fscanf(fd, "%s", op);
			while (code == 1) begin
				if (op == "#") begin
					code = $fgets(line, fd);
				end else if (op == "W") begin
					code = $fscanf(fd, "%s %h %h", name, f[0], f[1]);
					bus_write(name, f[0][`IO_ADDR_W-1:0], f[1]);
				end else if (op == "R") begin
					code = $fscanf(fd, "%s %h %h", name, f[0], f[1]);
					bus_read(name, f[0][`IO_ADDR_W-1:0], f[1]);
				end else if (op == "D") begin
					code = $fscanf(fd, "%s %d %h %h %h %h %h %h %h %h %h", name, link,
						f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
					stream_word(name, link, f[0], f[1], f[2], f[3], f[4],
						f[5], f[6], f[7], f[8]);
				end else if (op == "I") begin
					code = $fscanf(fd, "%s %d", name, count);
					idle_words(count);
				end else begin
					$display("unknown operation %s in the test file", op);
					n_errors++;
				end
				code = $fscanf(fd, "%s", op);
			end
			$fclose(fd);
		end

		drive_quiet();
		@(negedge in_clk160);
		$display("summary: %0d tests, %0d failed, %0d check errors", n_tests, n_failed,
			n_errors);
		if (file_ok && n_errors == 0 && n_tests > 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- logic/io_links_top.sv
`timescale 1ns/1ns
`include "io_links_consts.svh"

module io_links_top (
	input logic in_clk160,
	input logic arst_n,
	// Transmit stream in
	input logic [`IO_NLINKS-1:0][`IO_WORD_W-1:0] in_tdata,
	input logic [`IO_NLINKS-1:0] in_tvalid,
	// Pin side
	output logic [`IO_NLINKS-1:0][`IO_WORD_W-1:0] tx_data,
	output logic [`IO_NLINKS-1:0] tx_drive,
	input logic [`IO_NLINKS-1:0][`IO_WORD_W-1:0] rx_p_data,
	input logic [`IO_NLINKS-1:0][`IO_WORD_W-1:0] rx_n_data,
	input logic [`IO_NLINKS-1:0] rx_valid,
	// Receive stream out
	output logic [`IO_NLINKS-1:0][`IO_WORD_W-1:0] out_tdata,
	output logic [`IO_NLINKS-1:0] out_tvalid,
	// Register bus
	input logic [`IO_ADDR_W-1:0] reg_addr,
	input logic [`IO_REG_W-1:0] reg_wdata,
	input logic reg_wr,
	input logic reg_rd,
	output logic [`IO_REG_W-1:0] reg_rdata,
	output logic reg_rdack,
	output logic reg_wrack
);
	import io_links_pkg::*;

	link_ctrl_t [`IO_NLINKS-1:0] ctrl;
	link_stat_t [`IO_NLINKS-1:0] stat;

	//////////////////////////////////////////////////
	// Shared register bank
	//////////////////////////////////////////////////

	io_reg_bank io_reg_bank_inst (
		.in_clk160 (in_clk160),
		.arst_n (arst_n),
		.reg_addr (reg_addr),
		.reg_wdata (reg_wdata),
		.reg_wr (reg_wr),
		.reg_rd (reg_rd),
		.stat (stat),
		.reg_rdata (reg_rdata),
		.reg_rdack (reg_rdack),
		.reg_wrack (reg_wrack),
		.ctrl (ctrl)
	);

	//////////////////////////////////////////////////
	// One pipeline per link
	//////////////////////////////////////////////////

	for (genvar i = 0; i < `IO_NLINKS; i++) begin : g_link
		link_word_if word_if ();
		link_count_if cnt_if ();

		// tx -> rx over word_if, rx -> counters over cnt_if
		link_tx_stage link_tx_stage_inst (
			.in_clk160 (in_clk160),
			.arst_n (arst_n),
			.ctrl (ctrl[i]),
			.in_word (in_tdata[i]),
			.in_valid (in_tvalid[i]),
			.tx_data (tx_data[i]),
			.tx_drive (tx_drive[i]),
			.word (word_if)
		);

		link_rx_stage link_rx_stage_inst (
			.in_clk160 (in_clk160),
			.arst_n (arst_n),
			.rx_p_data (rx_p_data[i]),
			.rx_n_data (rx_n_data[i]),
			.rx_valid (rx_valid[i]),
			.word (word_if),
			.out_tdata (out_tdata[i]),
			.out_tvalid (out_tvalid[i]),
			.cnt (cnt_if)
		);

		link_counters link_counters_inst (
			.in_clk160 (in_clk160),
			.arst_n (arst_n),
			.cnt (cnt_if),
			.stat (stat[i])
		);
	end

endmodule

//--- logic/link_counters.sv
`timescale 1ns/1ns
`include "io_links_consts.svh"

module link_counters (
	input logic in_clk160,
	input logic arst_n,
	link_count_if.dst cnt,
	output io_links_pkg::link_stat_t stat
);

	localparam int SUM_W = `IO_CNT_W + 1;

	logic [`IO_CNT_W-1:0] bits_q;
	logic [`IO_CNT_W-1:0] errs_q;
	logic [`IO_CNT_W-1:0] snap_bits;
	logic [`IO_CNT_W-1:0] snap_errs;
	logic seen_q;
	logic [SUM_W-1:0] bits_sum;
	logic [SUM_W-1:0] errs_sum;
	logic [`IO_CNT_W-1:0] bits_nxt;
	logic [`IO_CNT_W-1:0] errs_nxt;

	//////////////////////////////////////////////////
	// Saturating add
	//////////////////////////////////////////////////

	// Extra top bit flags the wrap
	assign bits_sum = {1'b0, bits_q} + SUM_W'(cnt.bit_inc);
	assign errs_sum = {1'b0, errs_q} + SUM_W'(cnt.err_inc);
	assign bits_nxt = bits_sum[SUM_W-1] ? '1 : bits_sum[`IO_CNT_W-1:0];
	assign errs_nxt = errs_sum[SUM_W-1] ? '1 : errs_sum[`IO_CNT_W-1:0];

	always_ff @(posedge in_clk160 or negedge arst_n) begin
		if (!arst_n) begin
			bits_q <= '0;
			errs_q <= '0;
			snap_bits <= '0;
			snap_errs <= '0;
			seen_q <= 1'b0;
		end else if (cnt.clear) begin
			// Clear wins over count and latch
			bits_q <= '0;
			errs_q <= '0;
			snap_bits <= '0;
			snap_errs <= '0;
			seen_q <= 1'b0;
		end else begin
			if (cnt.inc_valid) begin
				bits_q <= bits_nxt;
				errs_q <= errs_nxt;
				seen_q <= 1'b1;
			end
			// Snapshot takes the counts before this cycle's add
			if (cnt.latch) begin
				snap_bits <= bits_q;
				snap_errs <= errs_q;
			end
		end
	end

	assign stat = '{bits: snap_bits, errs: snap_errs, seen_valid: seen_q};

	// Mismatches are a subset of the received bits
	a_err_le_bits: assert property (@(posedge in_clk160) disable iff (!arst_n)
		cnt.inc_valid |-> (cnt.err_inc <= cnt.bit_inc));

	// Live count never goes back unless cleared
	a_bits_monotonic: assert property (@(posedge in_clk160) disable iff (!arst_n)
		!cnt.clear |=> (bits_q >= $past(bits_q)));

endmodule

//--- logic/link_rx_stage.sv
`timescale 1ns/1ns
`include "io_links_consts.svh"

module link_rx_stage (
	input logic in_clk160,
	input logic arst_n,
	input logic [`IO_WORD_W-1:0] rx_p_data,
	input logic [`IO_WORD_W-1:0] rx_n_data,
	input logic rx_valid,
	link_word_if.dst word,
	output logic [`IO_WORD_W-1:0] out_tdata,
	output logic out_tvalid,
	link_count_if.src cnt
);
	import io_links_pkg::*;

	logic [`IO_WORD_W-1:0] p_q;
	logic [`IO_WORD_W-1:0] n_q;
	logic inc_q;
	link_inc_t diff_bits;

	//////////////////////////////////////////////////
	// Sample and output registers
	//////////////////////////////////////////////////

	always_ff @(posedge in_clk160) begin
		p_q <= rx_p_data;
		n_q <= rx_n_data;
		// Bypass word is already one cycle old, this makes two
		if (word.ctrl.bypass) begin
			out_tdata <= word.bypass_word;
		end else begin
			out_tdata <= rx_p_data ^ {`IO_WORD_W{word.ctrl.invert}};
		end
	end

	always_ff @(posedge in_clk160 or negedge arst_n) begin
		if (!arst_n) begin
			out_tvalid <= 1'b0;
			inc_q <= 1'b0;
		end else begin
			out_tvalid <= word.ctrl.run & (word.ctrl.bypass ? word.tx_valid : rx_valid);
			// Count pin words only, bypass has no bearing here
			inc_q <= word.ctrl.run & rx_valid;
		end
	end

	//////////////////////////////////////////////////
	// Count increments
	//////////////////////////////////////////////////

	// P/N mismatch per bit of the sampled word
	always_comb begin
		diff_bits = '0;
		for (int b = 0; b < `IO_WORD_W; b++) begin
			diff_bits = diff_bits + link_inc_t'(p_q[b] ^ n_q[b]);
		end
	end

	// Whole word counted every valid cycle
	assign cnt.bit_inc = link_inc_t'(`IO_WORD_W);
	assign cnt.err_inc = diff_bits;
	assign cnt.inc_valid = inc_q;

	// Counter commands straight through
	assign cnt.clear = word.ctrl.clear;
	assign cnt.latch = word.ctrl.latch;

endmodule

//--- logic/link_tx_stage.sv
`timescale 1ns/1ns
`include "io_links_consts.svh"

module link_tx_stage (
	input logic in_clk160,
	input logic arst_n,
	input io_links_pkg::link_ctrl_t ctrl,
	input logic [`IO_WORD_W-1:0] in_word,
	input logic in_valid,
	output logic [`IO_WORD_W-1:0] tx_data,
	output logic tx_drive,
	link_word_if.src word
);

	//////////////////////////////////////////////////
	// Word registers
	//////////////////////////////////////////////////

	// Pin word and raw copy, both one cycle behind the input
	always_ff @(posedge in_clk160) begin
		word.tx_word <= in_word ^ {`IO_WORD_W{ctrl.invert}};
		// Raw copy for the bypass loop
		word.bypass_word <= in_word;
	end

	// Pin sees the registered word directly
	assign tx_data = word.tx_word;

	//////////////////////////////////////////////////
	// Drive enable and valid
	//////////////////////////////////////////////////

	always_ff @(posedge in_clk160 or negedge arst_n) begin
		if (!arst_n) begin
			tx_drive <= 1'b0;
			word.tx_valid <= 1'b0;
		end else begin
			// Drive only valid words on a running, non-tristated link
			tx_drive <= in_valid & ~ctrl.tristate & ctrl.run;
			word.tx_valid <= in_valid;
		end
	end

	// Control goes on unregistered, rx stage registers its own outputs
	assign word.ctrl = ctrl;

endmodule

//--- logic/io_reg_bank.sv
`timescale 1ns/1ns
`include "io_links_consts.svh"

module io_reg_bank (
	input logic in_clk160,
	input logic arst_n,
	input logic [`IO_ADDR_W-1:0] reg_addr,
	input logic [`IO_REG_W-1:0] reg_wdata,
	input logic reg_wr,
	input logic reg_rd,
	input io_links_pkg::link_stat_t [`IO_NLINKS-1:0] stat,
	output logic [`IO_REG_W-1:0] reg_rdata,
	output logic reg_rdack,
	output logic reg_wrack,
	output io_links_pkg::link_ctrl_t [`IO_NLINKS-1:0] ctrl
);

	// Address split into block number and offset in block
	localparam int OFS_W = $clog2(`IO_REGS_PER_LINK);
	localparam int BLK_W = `IO_ADDR_W - OFS_W;

	localparam logic [OFS_W-1:0] OFS_CTRL = OFS_W'(`IO_OFS_CTRL);
	localparam logic [OFS_W-1:0] OFS_BITS = OFS_W'(`IO_OFS_BITS);
	localparam logic [OFS_W-1:0] OFS_ERRS = OFS_W'(`IO_OFS_ERRS);
	localparam logic [OFS_W-1:0] OFS_STAT = OFS_W'(`IO_OFS_STAT);

	// Reset values, only resetn comes up set
	localparam logic [`IO_GCTRL_W-1:0] GLB_DEFAULT = `IO_GCTRL_W'(1) << `IO_BIT_RESETN;
	localparam logic [`IO_CTRL_W-1:0] LINK_DEFAULT = `IO_CTRL_W'(1) << `IO_BIT_RESETN;

	// Command bits that drop after one cycle
	localparam logic [`IO_GCTRL_W-1:0] GLB_SELF_CLR =
		(`IO_GCTRL_W'(1) << `IO_BIT_CNTRST) | (`IO_GCTRL_W'(1) << `IO_BIT_LATCH);
	localparam logic [`IO_CTRL_W-1:0] LINK_SELF_CLR =
		(`IO_CTRL_W'(1) << `IO_BIT_CNTRST) | (`IO_CTRL_W'(1) << `IO_BIT_LATCH);

	logic [BLK_W-1:0] blk;
	logic [OFS_W-1:0] ofs;
	logic wr_glb;
	logic [`IO_NLINKS-1:0] wr_link;
	logic [`IO_GCTRL_W-1:0] glb_q;
	logic [`IO_CTRL_W-1:0] link_q [`IO_NLINKS];
	logic [`IO_REG_W-1:0] rd_mux;

	assign blk = reg_addr[`IO_ADDR_W-1:OFS_W];
	assign ofs = reg_addr[OFS_W-1:0];

	//////////////////////////////////////////////////
	// Write decode
	//////////////////////////////////////////////////

	// Block 0 is global, block i+1 is link i
	// Other offsets are read-only, writes there only get acked
	assign wr_glb = reg_wr && (blk == '0) && (ofs == OFS_CTRL);

	always_comb begin
		for (int i = 0; i < `IO_NLINKS; i++) begin
			wr_link[i] = reg_wr && (blk == BLK_W'(i + 1)) && (ofs == OFS_CTRL);
		end
	end

	always_ff @(posedge in_clk160 or negedge arst_n) begin
		if (!arst_n) begin
			glb_q <= GLB_DEFAULT;
			for (int i = 0; i < `IO_NLINKS; i++) begin
				link_q[i] <= LINK_DEFAULT;
			end
		end else begin
			// Commands held one cycle then dropped
			glb_q <= glb_q & ~GLB_SELF_CLR;
			if (wr_glb) begin
				glb_q <= reg_wdata[`IO_GCTRL_W-1:0];
			end
			for (int i = 0; i < `IO_NLINKS; i++) begin
				link_q[i] <= link_q[i] & ~LINK_SELF_CLR;
				if (wr_link[i]) begin
					link_q[i] <= reg_wdata[`IO_CTRL_W-1:0];
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Readback
	//////////////////////////////////////////////////

	always_comb begin
		// Unmapped reads give zero
		rd_mux = '0;
		if ((blk == '0) && (ofs == OFS_CTRL)) begin
			rd_mux = `IO_REG_W'(glb_q);
		end
		for (int i = 0; i < `IO_NLINKS; i++) begin
			if (blk == BLK_W'(i + 1)) begin
				case (ofs)
					OFS_CTRL: rd_mux = `IO_REG_W'(link_q[i]);
					OFS_BITS: rd_mux = `IO_REG_W'(stat[i].bits);
					OFS_ERRS: rd_mux = `IO_REG_W'(stat[i].errs);
					OFS_STAT: rd_mux = `IO_REG_W'(stat[i].seen_valid);
					default: rd_mux = '0;
				endcase
			end
		end
	end

	// Data held until the next read
	always_ff @(posedge in_clk160) begin
		if (reg_rd) begin
			reg_rdata <= rd_mux;
		end
	end

	// Acks one cycle after the strobe
	always_ff @(posedge in_clk160 or negedge arst_n) begin
		if (!arst_n) begin
			reg_wrack <= 1'b0;
			reg_rdack <= 1'b0;
		end else begin
			reg_wrack <= reg_wr;
			reg_rdack <= reg_rd;
		end
	end

	//////////////////////////////////////////////////
	// Effective control per link
	//////////////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < `IO_NLINKS; i++) begin
			ctrl[i].run = glb_q[`IO_BIT_RESETN] & link_q[i][`IO_BIT_RESETN];
			// Counters also held clear while link is down
			ctrl[i].clear = glb_q[`IO_BIT_CNTRST] | link_q[i][`IO_BIT_CNTRST] | ~ctrl[i].run;
			ctrl[i].latch = glb_q[`IO_BIT_LATCH] | link_q[i][`IO_BIT_LATCH];
			ctrl[i].bypass = link_q[i][`IO_BIT_BYPASS];
			ctrl[i].tristate = link_q[i][`IO_BIT_TRISTATE];
			ctrl[i].invert = link_q[i][`IO_BIT_INVERT];
		end
	end

	// Bus master never issues both strobes at once
	a_one_strobe: assert property (@(posedge in_clk160) disable iff (!arst_n)
		!(reg_wr && reg_rd));

	// Write ack shows with the written value already in the register
	a_glb_write_acked: assert property (@(posedge in_clk160) disable iff (!arst_n)
		wr_glb |=> reg_wrack && (glb_q == $past(reg_wdata[`IO_GCTRL_W-1:0])));

	for (genvar i = 0; i < `IO_NLINKS; i++) begin : g_wr_chk
		// Self-clear must not eat the command bits on the write edge
		a_link_write_acked: assert property (@(posedge in_clk160) disable iff (!arst_n)
			wr_link[i] |=> reg_wrack && (link_q[i] == $past(reg_wdata[`IO_CTRL_W-1:0])));
	end

endmodule

//--- logic/io_links_if.sv
`timescale 1ns/1ns
`include "io_links_consts.svh"

//////////////////////////////////////////////////
// Transmit stage to receive stage
//////////////////////////////////////////////////

interface link_word_if;
	import io_links_pkg::*;

	// Word as driven to the pin, inversion applied
	logic [`IO_WORD_W-1:0] tx_word;
	// Registered valid of the raw word
	logic tx_valid;
	// Raw word, one cycle behind the top input
	logic [`IO_WORD_W-1:0] bypass_word;
	// Control struct forwarded alongside
	link_ctrl_t ctrl;

	modport src (output tx_word, tx_valid, bypass_word, ctrl);
	// Pin word stays on the transmit side
	modport dst (input tx_valid, bypass_word, ctrl);
endinterface

//////////////////////////////////////////////////
// Receive stage to counters
//////////////////////////////////////////////////

interface link_count_if;
	import io_links_pkg::*;

	link_inc_t bit_inc;
	link_inc_t err_inc;
	// One add per cycle while high
	logic inc_valid;
	logic clear;
	logic latch;

	modport src (output bit_inc, err_inc, inc_valid, clear, latch);
	modport dst (input bit_inc, err_inc, inc_valid, clear, latch);
endinterface

//--- logic/io_links_pkg.sv
`include "io_links_consts.svh"

package io_links_pkg;

	//////////////////////////////////////////////////
	// Effective per-link control
	//////////////////////////////////////////////////

	// Global and link bits already merged by the register bank
	typedef struct packed {
		// Link out of reset
		logic run;
		// Zero live counters and snapshot
		logic clear;
		// Copy live counters into snapshot
		logic latch;
		// Loop transmit words back instead of pin data
		logic bypass;
		// Keep pin undriven
		logic tristate;
		// Flip every bit of the word
		logic invert;
	} link_ctrl_t;

	//////////////////////////////////////////////////
	// Per-link status seen by the register bus
	//////////////////////////////////////////////////

	typedef struct packed {
		// Latched totals
		logic [`IO_CNT_W-1:0] bits;
		logic [`IO_CNT_W-1:0] errs;
		// At least one valid word since last clear
		logic seen_valid;
	} link_stat_t;

	// Enough bits to hold a full word's bit count
	typedef logic [$clog2(`IO_WORD_W + 1)-1:0] link_inc_t;

endpackage

//--- logic/io_links_consts.svh
`ifndef IO_LINKS_CONSTS_SVH
`define IO_LINKS_CONSTS_SVH

// Link count and data path widths
`define IO_NLINKS 2
`define IO_WORD_W 8
`define IO_CNT_W 32

// Register bus geometry
`define IO_REG_W 32
`define IO_ADDR_W 6
`define IO_REGS_PER_LINK 4

// Offsets inside one link block
`define IO_OFS_CTRL 0
`define IO_OFS_BITS 1
`define IO_OFS_ERRS 2
`define IO_OFS_STAT 3

// Control register layout, global reg uses the low three bits only
`define IO_CTRL_W 6
`define IO_GCTRL_W 3
`define IO_BIT_RESETN 0
`define IO_BIT_CNTRST 1
`define IO_BIT_LATCH 2
`define IO_BIT_BYPASS 3
`define IO_BIT_TRISTATE 4
`define IO_BIT_INVERT 5

`endif
